/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := axis_weight_rotator_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/axis_weight_rotator.sv */
`timescale 1ns/100ps

module axis_weight_rotator #(
  parameter int WORD_WIDTH      = rotator_cfg_pkg::word_width_def,
  parameter int CORES           = rotator_cfg_pkg::cores_def,
  parameter int KERNEL_W_MAX    = rotator_cfg_pkg::kernel_w_max_def,
  parameter int KERNEL_H_MAX    = rotator_cfg_pkg::kernel_h_max_def,
  parameter int IM_CIN_MAX      = rotator_cfg_pkg::im_cin_max_def,
  parameter int IM_BLOCKS_MAX   = rotator_cfg_pkg::im_blocks_max_def,
  parameter int LATENCY_BRAM    = rotator_cfg_pkg::latency_bram_def,
  parameter int S_WEIGHTS_WIDTH = rotator_cfg_pkg::s_weights_width_def
) (
  input  logic                                       aclk,
  input  logic                                       reset,
  input  logic                                       s_axis_tvalid,
  output logic                                       s_axis_tready,
  input  logic [S_WEIGHTS_WIDTH-1:0]                 s_axis_tdata,
  input  logic                                       s_axis_tlast,
  output logic                                       m_axis_tvalid,
  input  logic                                       m_axis_tready,
  output logic [WORD_WIDTH*CORES*KERNEL_W_MAX-1:0]   m_axis_tdata,
  output logic [rotator_types_pkg::tuser_width-1:0]  m_axis_tuser,
  output logic                                       m_axis_tlast
);

  import rotator_types_pkg::*;

  localparam int ROW_W     = WORD_WIDTH * CORES * KERNEL_W_MAX;
  localparam int ADDR_BITS = $clog2(KERNEL_H_MAX * IM_CIN_MAX) + 1;

  logic                   wr_en;
  logic [ADDR_BITS-1:0]   wr_addr;
  logic [ROW_W-1:0]       wr_data;
  logic                   rd_en;
  logic [ADDR_BITS-1:0]   rd_addr;
  logic [ROW_W-1:0]       rd_data;
  logic [tuser_width-1:0] rd_user;
  logic                   rd_last;
  logic                   space;

  weight_row_if #(.ROW_WIDTH(ROW_W)) row_bus ();

  weight_row_packer #(
    .WORD_WIDTH      (WORD_WIDTH),
    .CORES           (CORES),
    .KERNEL_W_MAX    (KERNEL_W_MAX),
    .S_WEIGHTS_WIDTH (S_WEIGHTS_WIDTH)
  ) packer (
    .aclk          (aclk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .row           (row_bus.packer)
  );

  weight_rotator_ctrl #(
    .WORD_WIDTH    (WORD_WIDTH),
    .CORES         (CORES),
    .KERNEL_W_MAX  (KERNEL_W_MAX),
    .KERNEL_H_MAX  (KERNEL_H_MAX),
    .IM_CIN_MAX    (IM_CIN_MAX),
    .IM_BLOCKS_MAX (IM_BLOCKS_MAX)
  ) ctrl (
    .aclk    (aclk),
    .reset   (reset),
    .row     (row_bus.ctrl),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .space   (space),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_user (rd_user),
    .rd_last (rd_last)
  );

  weight_bank_ram #(
    .WORD_WIDTH   (WORD_WIDTH),
    .CORES        (CORES),
    .KERNEL_W_MAX (KERNEL_W_MAX),
    .KERNEL_H_MAX (KERNEL_H_MAX),
    .IM_CIN_MAX   (IM_CIN_MAX),
    .LATENCY_BRAM (LATENCY_BRAM)
  ) ram (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  weight_out_buffer #(
    .WORD_WIDTH   (WORD_WIDTH),
    .CORES        (CORES),
    .KERNEL_W_MAX (KERNEL_W_MAX),
    .LATENCY_BRAM (LATENCY_BRAM)
  ) out_buf (
    .aclk          (aclk),
    .reset         (reset),
    .rd_en         (rd_en),
    .rd_user       (rd_user),
    .rd_last       (rd_last),
    .rd_data       (rd_data),
    .space         (space),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

/* rtl/rotator_cfg_pkg.sv */
package rotator_cfg_pkg;

  // one weight word and the number of cores fed side by side
  localparam int word_width_def = 8;
  localparam int cores_def = 2;

  // rows of a kernel are kernel_w_max words wide per core
  localparam int kernel_w_max_def = 3;
  localparam int kernel_h_max_def = 3;

  // largest layer a single packet may describe
  localparam int im_cin_max_def = 8;
  localparam int im_blocks_max_def = 8;

  localparam int latency_bram_def = 2; // read latency including the output register

  localparam int s_weights_width_def = 16; // narrow input beat

  // input beats that make up one kernel row on the wide side
  localparam int beats_per_row =
    word_width_def * cores_def * kernel_w_max_def / s_weights_width_def;

endpackage

/* rtl/rotator_types_pkg.sv */
package rotator_types_pkg;

  typedef enum logic [1:0] {
    idle   = 2'd0,
    rotate = 2'd1, // walking a full bank once per image block
    drain  = 2'd2  // one spare cycle after the bank is handed back
  } rotator_state_e;

  // bit positions inside the output tuser
  typedef enum logic [1:0] {
    is_top_block    = 2'd0,
    is_bottom_block = 2'd1,
    is_1x1          = 2'd2,
    is_cin_last     = 2'd3
  } tuser_bit_e;

  localparam int tuser_width = 4;

  // configuration carried in the low bits of the first beat of a packet
  typedef struct packed {
    logic       is_1x1;   // kernel height of one instead of the maximum
    logic [2:0] cin_1;    // input channels minus one
    logic [2:0] blocks_1; // image blocks minus one
  } weight_header_t;

  localparam int header_width = $bits(weight_header_t);

endpackage

/* rtl/weight_bank_ram.sv */
`timescale 1ns/100ps

module weight_bank_ram #(
  parameter int WORD_WIDTH   = rotator_cfg_pkg::word_width_def,
  parameter int CORES        = rotator_cfg_pkg::cores_def,
  parameter int KERNEL_W_MAX = rotator_cfg_pkg::kernel_w_max_def,
  parameter int KERNEL_H_MAX = rotator_cfg_pkg::kernel_h_max_def,
  parameter int IM_CIN_MAX   = rotator_cfg_pkg::im_cin_max_def,
  parameter int LATENCY_BRAM = rotator_cfg_pkg::latency_bram_def
) (
  input  logic                                           aclk,
  input  logic                                           wr_en,
  input  logic [$clog2(KERNEL_H_MAX*IM_CIN_MAX):0]       wr_addr,
  input  logic [WORD_WIDTH*CORES*KERNEL_W_MAX-1:0]       wr_data,
  input  logic                                           rd_en,
  input  logic [$clog2(KERNEL_H_MAX*IM_CIN_MAX):0]       rd_addr,
  output logic [WORD_WIDTH*CORES*KERNEL_W_MAX-1:0]       rd_data
);

  localparam int ROW_W     = WORD_WIDTH * CORES * KERNEL_W_MAX;
  localparam int ADDR_BITS = $clog2(KERNEL_H_MAX * IM_CIN_MAX) + 1;

  logic [ROW_W-1:0] mem [2**ADDR_BITS]; // top address bit selects the bank
  logic [ROW_W-1:0] pipe [LATENCY_BRAM];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // first stage is the array read and the rest model the output registers
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      pipe[0] <= mem[rd_addr];
    end
    for (int i = 1; i < LATENCY_BRAM; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign rd_data = pipe[LATENCY_BRAM-1];

endmodule

/* rtl/weight_out_buffer.sv */
`timescale 1ns/100ps

module weight_out_buffer #(
  parameter int WORD_WIDTH   = rotator_cfg_pkg::word_width_def,
  parameter int CORES        = rotator_cfg_pkg::cores_def,
  parameter int KERNEL_W_MAX = rotator_cfg_pkg::kernel_w_max_def,
  parameter int LATENCY_BRAM = rotator_cfg_pkg::latency_bram_def
) (
  input  logic                                       aclk,
  input  logic                                       reset,
  input  logic                                       rd_en,
  input  logic [rotator_types_pkg::tuser_width-1:0]  rd_user,
  input  logic                                       rd_last,
  input  logic [WORD_WIDTH*CORES*KERNEL_W_MAX-1:0]   rd_data,
  output logic                                       space,
  output logic                                       m_axis_tvalid,
  input  logic                                       m_axis_tready,
  output logic [WORD_WIDTH*CORES*KERNEL_W_MAX-1:0]   m_axis_tdata,
  output logic [rotator_types_pkg::tuser_width-1:0]  m_axis_tuser,
  output logic                                       m_axis_tlast
);

  import rotator_types_pkg::*;

  localparam int ROW_W    = WORD_WIDTH * CORES * KERNEL_W_MAX;
  localparam int DEPTH    = LATENCY_BRAM + 1;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [LATENCY_BRAM-1:0]   en_pipe;
  logic [LATENCY_BRAM-1:0]   last_pipe;
  logic [tuser_width-1:0]    user_pipe [LATENCY_BRAM];
  logic [ROW_W+tuser_width:0] fifo [DEPTH]; // {last, user, data}
  logic [PTR_BITS-1:0]       wr_ptr;
  logic [PTR_BITS-1:0]       rd_ptr;
  logic [CNT_BITS-1:0]       count;
  logic [CNT_BITS-1:0]       in_flight;
  logic                      land;
  logic                      pop;

  assign land = en_pipe[LATENCY_BRAM-1]; // RAM data for this read is on rd_data now
  assign pop  = m_axis_tvalid && m_axis_tready;

  // every read already issued owns a slot, so the FIFO can never overflow
  assign space = (count + in_flight) < CNT_BITS'(DEPTH);

  always_ff @(posedge aclk) begin
    last_pipe[0] <= rd_last;
    user_pipe[0] <= rd_user;
    for (int i = 1; i < LATENCY_BRAM; i++) begin
      last_pipe[i] <= last_pipe[i-1];
      user_pipe[i] <= user_pipe[i-1];
    end
    if (land) begin
      fifo[wr_ptr] <= {last_pipe[LATENCY_BRAM-1], user_pipe[LATENCY_BRAM-1], rd_data};
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      en_pipe   <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_flight <= '0;
    end else begin
      en_pipe[0] <= rd_en;
      for (int i = 1; i < LATENCY_BRAM; i++) begin
        en_pipe[i] <= en_pipe[i-1];
      end
      if (land) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + CNT_BITS'(land) - CNT_BITS'(pop);
      in_flight <= in_flight + CNT_BITS'(rd_en) - CNT_BITS'(land);
    end
  end

  assign m_axis_tvalid = count != '0;
  assign {m_axis_tlast, m_axis_tuser, m_axis_tdata} = fifo[rd_ptr];

endmodule

/* rtl/weight_rotator_ctrl.sv */
`timescale 1ns/100ps

module weight_rotator_ctrl #(
  parameter int WORD_WIDTH    = rotator_cfg_pkg::word_width_def,
  parameter int CORES         = rotator_cfg_pkg::cores_def,
  parameter int KERNEL_W_MAX  = rotator_cfg_pkg::kernel_w_max_def,
  parameter int KERNEL_H_MAX  = rotator_cfg_pkg::kernel_h_max_def,
  parameter int IM_CIN_MAX    = rotator_cfg_pkg::im_cin_max_def,
  parameter int IM_BLOCKS_MAX = rotator_cfg_pkg::im_blocks_max_def
) (
  input  logic                                       aclk,
  input  logic                                       reset,
  weight_row_if.ctrl                                 row,
  output logic                                       wr_en,
  output logic [$clog2(KERNEL_H_MAX*IM_CIN_MAX):0]   wr_addr,
  output logic [WORD_WIDTH*CORES*KERNEL_W_MAX-1:0]   wr_data,
  input  logic                                       space,
  output logic                                       rd_en,
  output logic [$clog2(KERNEL_H_MAX*IM_CIN_MAX):0]   rd_addr,
  output logic [rotator_types_pkg::tuser_width-1:0]  rd_user,
  output logic                                       rd_last
);

  import rotator_types_pkg::*;

  localparam int ROW_BITS = $clog2(KERNEL_H_MAX * IM_CIN_MAX);
  localparam int KR_BITS  = $clog2(KERNEL_H_MAX);
  localparam int CH_BITS  = $clog2(IM_CIN_MAX);
  localparam int BLK_BITS = $clog2(IM_BLOCKS_MAX);

  logic                wr_bank;
  logic                rd_bank;
  logic [1:0]          full;
  weight_header_t      hdr [2];
  weight_header_t      cur;
  logic [ROW_BITS-1:0] wr_row;
  logic [ROW_BITS-1:0] rd_row;
  rotator_state_e      state;
  logic [BLK_BITS-1:0] blk;
  logic [CH_BITS-1:0]  ch;
  logic [KR_BITS-1:0]  kr;
  logic [KR_BITS-1:0]  kh_1;
  logic                accept;
  logic                kr_done;
  logic                ch_done;
  logic                blk_done;

  assign row.ready = !full[wr_bank];
  assign accept    = row.valid && row.ready;

  // rows land in packet order, so the bank holds them channel-major
  assign wr_en   = accept && !row.is_header;
  assign wr_addr = {wr_bank, wr_row};
  assign wr_data = row.data;

  always_ff @(posedge aclk) begin
    if (accept && row.is_header) begin
      hdr[wr_bank] <= weight_header_t'(row.data[header_width-1:0]);
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_bank <= 1'b0;
      wr_row  <= '0;
      full    <= '0;
    end else begin
      if (accept) begin
        if (row.is_header) begin
          wr_row <= '0;
        end else begin
          wr_row <= wr_row + 1'b1;
          if (row.last) begin
            full[wr_bank] <= 1'b1;
            wr_bank       <= !wr_bank;
          end
        end
      end
      if (rd_en && rd_last) begin
        full[rd_bank] <= 1'b0; // bank free once its final read is out
      end
    end
  end

  assign cur      = hdr[rd_bank];
  assign kh_1     = cur.is_1x1 ? '0 : KR_BITS'(KERNEL_H_MAX - 1);
  assign kr_done  = kr == kh_1;
  assign ch_done  = ch == CH_BITS'(cur.cin_1);
  assign blk_done = blk == BLK_BITS'(cur.blocks_1);

  assign rd_en   = (state == rotate) && space;
  assign rd_addr = {rd_bank, rd_row};

  always_comb begin
    rd_user                  = '0;
    rd_user[is_top_block]    = blk == '0;
    rd_user[is_bottom_block] = blk_done;
    rd_user[is_1x1]          = cur.is_1x1;
    rd_user[is_cin_last]     = ch_done;
  end

  assign rd_last = kr_done && ch_done && blk_done;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state   <= idle;
      rd_bank <= 1'b0;
      rd_row  <= '0;
      blk     <= '0;
      ch      <= '0;
      kr      <= '0;
    end else begin
      case (state)
        idle: begin
          if (full[rd_bank]) begin
            state <= rotate;
          end
        end
        rotate: begin
          if (rd_en) begin
            if (!kr_done) begin
              kr     <= kr + 1'b1;
              rd_row <= rd_row + 1'b1;
            end else begin
              kr <= '0;
              if (!ch_done) begin
                ch     <= ch + 1'b1;
                rd_row <= rd_row + 1'b1;
              end else begin
                ch     <= '0;
                rd_row <= '0; // every block replays the whole bank
                if (!blk_done) begin
                  blk <= blk + 1'b1;
                end else begin
                  blk     <= '0;
                  rd_bank <= !rd_bank;
                  state   <= drain;
                end
              end
            end
          end
        end
        drain: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* rtl/weight_row_if.sv */
`timescale 1ns/100ps

interface weight_row_if #(
  parameter int ROW_WIDTH = 48
);

  logic                 valid;
  logic                 ready;
  logic                 is_header; // data holds a header in its low bits
  logic                 last;      // final row of the packet
  logic [ROW_WIDTH-1:0] data;

  modport packer (
    output valid,
    output is_header,
    output last,
    output data,
    input  ready
  );

  modport ctrl (
    input  valid,
    input  is_header,
    input  last,
    input  data,
    output ready
  );

endinterface

/* rtl/weight_row_packer.sv */
`timescale 1ns/100ps

module weight_row_packer #(
  parameter int WORD_WIDTH      = rotator_cfg_pkg::word_width_def,
  parameter int CORES           = rotator_cfg_pkg::cores_def,
  parameter int KERNEL_W_MAX    = rotator_cfg_pkg::kernel_w_max_def,
  parameter int S_WEIGHTS_WIDTH = rotator_cfg_pkg::s_weights_width_def
) (
  input  logic                       aclk,
  input  logic                       reset,
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready,
  input  logic [S_WEIGHTS_WIDTH-1:0] s_axis_tdata,
  input  logic                       s_axis_tlast,
  weight_row_if.packer               row
);

  localparam int ROW_W     = WORD_WIDTH * CORES * KERNEL_W_MAX;
  localparam int BEATS     = ROW_W / S_WEIGHTS_WIDTH;
  localparam int BEAT_BITS = $clog2(BEATS);

  logic [BEAT_BITS-1:0] beat_cnt;
  logic                 first; // next beat opens a packet
  logic                 beat;
  logic                 pop;

  // a held item blocks the input until the controller takes it
  assign s_axis_tready = !row.valid || row.ready;
  assign beat = s_axis_tvalid && s_axis_tready;
  assign pop  = row.valid && row.ready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      row.valid <= 1'b0;
      first     <= 1'b1;
      beat_cnt  <= '0;
    end else begin
      if (pop) begin
        row.valid <= 1'b0;
      end
      if (beat) begin
        if (first) begin
          row.valid <= 1'b1; // header goes out on its own
          first     <= s_axis_tlast;
        end else if (beat_cnt == BEAT_BITS'(BEATS - 1)) begin
          row.valid <= 1'b1;
          beat_cnt  <= '0;
          first     <= s_axis_tlast;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // the outgoing data doubles as the shift register and moves only on an accepted beat
  always_ff @(posedge aclk) begin
    if (beat) begin
      if (first) begin
        row.data      <= ROW_W'(s_axis_tdata);
        row.is_header <= 1'b1;
        row.last      <= 1'b0;
      end else begin
        row.data      <= {s_axis_tdata, row.data[ROW_W-1:S_WEIGHTS_WIDTH]}; // oldest beat ends lowest
        row.is_header <= 1'b0;
        row.last      <= s_axis_tlast;
      end
    end
  end

endmodule

/* tb.f */
rtl/rotator_cfg_pkg.sv
rtl/rotator_types_pkg.sv
rtl/weight_row_if.sv
rtl/weight_row_packer.sv
rtl/weight_bank_ram.sv
rtl/weight_rotator_ctrl.sv
rtl/weight_out_buffer.sv
rtl/axis_weight_rotator.sv
testbench/axis_weight_rotator_tb.sv

/* testbench/axis_weight_rotator_tb.sv */
`timescale 1ns/100ps

module axis_weight_rotator_tb;

  localparam int ROW_W   = 48;
  localparam int BEAT_W  = 16;
  localparam int BEATS   = 3;
  localparam int KH_MAX  = 3;
  localparam int TUSER_W = 4;
  localparam int TIMEOUT = 20000; // well above one bank rotation at the slowest output

  logic               aclk = 1'b0;
  logic               reset;
  logic               s_axis_tvalid;
  logic               s_axis_tready;
  logic [BEAT_W-1:0]  s_axis_tdata;
  logic               s_axis_tlast;
  logic               m_axis_tvalid;
  logic               m_axis_tready = 1'b0;
  logic [ROW_W-1:0]   m_axis_tdata;
  logic [TUSER_W-1:0] m_axis_tuser;
  logic               m_axis_tlast;

  integer data_seed  = 26;
  integer ready_seed = 26;
  int     ready_mode = 0; // 0 always ready, 1 half the time, 2 one cycle in four

  logic [ROW_W+TUSER_W:0] exp_q [$]; // {tlast, tuser, tdata} in output order
  int                     exp_rd = 0;
  logic                   held = 1'b0;
  logic [ROW_W-1:0]       held_data;
  logic [TUSER_W-1:0]     held_user;
  logic                   held_last;

  axis_weight_rotator dut0 (
    .aclk          (aclk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

  always #50 aclk = ~aclk;

  task automatic print_failure(input string detail);
    $display("%s", detail);
    $display("ERRORS FOUND");
  endtask

  // a stalled row must sit still until the sink takes it
  task automatic check_stall();
    assert (m_axis_tvalid) else begin
      print_failure("m_axis_tvalid dropped before the stalled row was taken");
      $fatal(1);
    end
    assert (m_axis_tdata == held_data) else begin
      print_failure($sformatf("Fail m_axis_tdata expected %h actual %h", held_data, m_axis_tdata));
      $fatal(1);
    end
    assert (m_axis_tuser == held_user) else begin
      print_failure($sformatf("Fail m_axis_tuser expected %h actual %h", held_user, m_axis_tuser));
      $fatal(1);
    end
    assert (m_axis_tlast == held_last) else begin
      print_failure($sformatf("Fail m_axis_tlast expected %h actual %h", held_last, m_axis_tlast));
      $fatal(1);
    end
  endtask

  task automatic check_row();
    logic [ROW_W+TUSER_W:0] expected;
    if (exp_rd >= exp_q.size()) begin
      print_failure("an output row arrived when no row was expected");
      $fatal(1);
    end else begin
      expected = exp_q[exp_rd];
      exp_rd++;
      assert (m_axis_tdata == expected[ROW_W-1:0]) else begin
        print_failure($sformatf("Fail m_axis_tdata expected %h actual %h",
                                expected[ROW_W-1:0], m_axis_tdata));
        $fatal(1);
      end
      assert (m_axis_tuser == expected[ROW_W+TUSER_W-1:ROW_W]) else begin
        print_failure($sformatf("Fail m_axis_tuser expected %h actual %h",
                                expected[ROW_W+TUSER_W-1:ROW_W], m_axis_tuser));
        $fatal(1);
      end
      assert (m_axis_tlast == expected[ROW_W+TUSER_W]) else begin
        print_failure($sformatf("Fail m_axis_tlast expected %h actual %h",
                                expected[ROW_W+TUSER_W], m_axis_tlast));
        $fatal(1);
      end
    end
  endtask

  always @(negedge aclk) begin
    logic [31:0] r;
    r = $random(ready_seed);
    case (ready_mode)
      0: m_axis_tready = 1'b1;
      1: m_axis_tready = r[0];
      default: m_axis_tready = r[1:0] == 2'b00;
    endcase
  end

  always @(posedge aclk) begin
    if (reset) begin
      held = 1'b0;
    end else begin
      if (held) begin
        check_stall();
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_row();
      end
      held      = m_axis_tvalid && !m_axis_tready;
      held_data = m_axis_tdata;
      held_user = m_axis_tuser;
      held_last = m_axis_tlast;
    end
  end

  task automatic send_beat(input logic [BEAT_W-1:0] data, input logic last);
    int   cycles;
    logic done;
    @(negedge aclk);
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = data;
    s_axis_tlast  = last;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge aclk);
      done = s_axis_tready; // beat moves on this edge when ready is high
      cycles++;
      if (!done && cycles >= TIMEOUT) begin
        print_failure("an input beat was not accepted before the timeout");
        $fatal(1);
      end
    end
  endtask

  task automatic send_packet(input logic one, input logic [2:0] cin_1, input logic [2:0] blocks_1);
    logic [ROW_W-1:0]   rows [$];
    logic [ROW_W-1:0]   row_val;
    logic [31:0]        r0;
    logic [31:0]        r1;
    logic [31:0]        r2;
    logic [TUSER_W-1:0] user;
    logic               last;
    int                 kh;
    int                 nc;
    int                 nb;
    kh = one ? 1 : KH_MAX;
    nc = int'(cin_1) + 1;
    nb = int'(blocks_1) + 1;
    for (int i = 0; i < kh * nc; i++) begin
      r0 = $random(data_seed);
      r1 = $random(data_seed);
      r2 = $random(data_seed);
      rows.push_back({r2[BEAT_W-1:0], r1[BEAT_W-1:0], r0[BEAT_W-1:0]});
    end
    // every block replays the bank in channel-major order with kernel rows inside
    for (int b = 0; b < nb; b++) begin
      for (int c = 0; c < nc; c++) begin
        for (int k = 0; k < kh; k++) begin
          user = {c == nc - 1, one, b == nb - 1, b == 0};
          last = (b == nb - 1) && (c == nc - 1) && (k == kh - 1);
          exp_q.push_back({last, user, rows[c * kh + k]});
        end
      end
    end
    send_beat({9'd0, one, cin_1, blocks_1}, 1'b0);
    for (int i = 0; i < kh * nc; i++) begin
      row_val = rows[i];
      for (int j = 0; j < BEATS; j++) begin
        send_beat(row_val[j*BEAT_W +: BEAT_W], (i == kh * nc - 1) && (j == BEATS - 1));
      end
    end
  endtask

  task automatic send_random_packet();
    logic [31:0] r;
    r = $random(data_seed);
    send_packet(r[1:0] == 2'b00, r[4:2], r[7:5]); // about one packet in four is 1x1
  endtask

  task automatic stop_input();
    @(negedge aclk);
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  task automatic set_ready_mode(input int mode);
    @(posedge aclk);
    ready_mode = mode;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_rd != exp_q.size()) begin
      @(negedge aclk);
      cycles++;
      if (exp_rd != exp_q.size() && cycles >= TIMEOUT) begin
        print_failure("expected output rows did not arrive before the timeout");
        $fatal(1);
      end
    end
  endtask

  initial begin
    reset         = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
    assert (s_axis_tready && !m_axis_tvalid) else begin
      print_failure("after reset s_axis_tready is low or m_axis_tvalid is high");
      $fatal(1);
    end

    repeat (4) send_random_packet();
    stop_input();
    wait_drain();

    send_packet(1'b1, 3'd0, 3'd0); // smallest packet with one row and one block
    send_packet(1'b0, 3'd7, 3'd0); // a full bank read once
    send_packet(1'b1, 3'd7, 3'd7);
    stop_input();
    wait_drain();

    set_ready_mode(1);
    repeat (6) send_random_packet();
    stop_input();
    wait_drain();

    // slow sink so both banks fill and the input has to stall
    set_ready_mode(2);
    repeat (3) send_random_packet();
    stop_input();
    wait_drain();

    if (!m_axis_tvalid) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      print_failure("output rows remained after every expected row had arrived");
      $fatal(1);
    end
  end

endmodule
